// ==== files.f ====
+incdir+logic
logic/mover_regs_pkg.sv
logic/mover_stream_pkg.sv
logic/register_bank.sv
logic/datapoint_store.sv
logic/data_mover.sv
logic/data_mover_top.sv
verif/data_mover_chk.sv
verif/data_mover_tb.sv

// ==== logic/data_mover.sv ====
// Channel sequencer that fetches one data point per active channel and can replay the last sweep
`timescale 1ns/10ps
`default_nettype none

`include "mover_settings.svh"

module data_mover (
    input wire logic clock,
    input wire logic reset,
    input wire logic start,
    input wire logic repeat_outputs,
    input wire logic out_ready,
    input wire mover_regs_pkg::channel_count_t n_channels,
    input wire mover_stream_pkg::src_addr_t source_address [`MOVER_MAX_CHANNELS],
    input wire mover_stream_pkg::dest_tag_t dest_tag [`MOVER_MAX_CHANNELS],
    input wire mover_stream_pkg::user_word_t user_value [`MOVER_MAX_CHANNELS],
    output logic request_valid,
    output mover_stream_pkg::src_addr_t request_address,
    input wire logic response_valid,
    input wire mover_stream_pkg::data_word_t response_data,
    output logic out_valid,
    output logic done,
    output mover_stream_pkg::data_word_t out_data,
    output mover_stream_pkg::dest_tag_t out_dest,
    output mover_stream_pkg::user_word_t out_user
);

    import mover_regs_pkg::*;
    import mover_stream_pkg::*;

    typedef enum logic [2:0] {
        idle,
        read_source,
        wait_response,
        send_buffered,
        wait_ready
    } mover_state_t;

    mover_state_t state;
    channel_idx_t channel;

    // Last word fetched for every channel, replayed by a repeat sweep
    data_word_t data_buffers [`MOVER_MAX_CHANNELS];

    // A word leaves the mover either from the store or from the replay buffers
    logic capture;
    logic replay;
    logic last_channel;

    assign capture = (state == wait_response) && response_valid;
    assign replay = (state == send_buffered);

    // Compared with >= so a count lowered mid sweep still ends the sweep
    assign last_channel = (channel_count_t'(channel) + channel_count_t'(1)) >= n_channels;

    // The response side is always ready, since only one request is ever in flight
    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            channel <= '0;
            request_valid <= 1'b0;
            out_valid <= 1'b0;
            done <= 1'b0;
        end else begin
            // Requests, words and done are single cycle pulses
            request_valid <= 1'b0;
            out_valid <= 1'b0;
            done <= 1'b0;
            case (state)
                idle: begin
                    // Repeat has priority when both arrive together
                    if (repeat_outputs) begin
                        state <= send_buffered;
                    end else if (start) begin
                        state <= read_source;
                    end
                end
                read_source: begin
                    request_valid <= 1'b1;
                    state <= wait_response;
                end
                wait_response: begin
                    if (response_valid) begin
                        out_valid <= 1'b1;
                        if (last_channel) begin
                            done <= 1'b1;
                            channel <= '0;
                            state <= idle;
                        end else begin
                            channel <= channel + 1'b1;
                            state <= read_source;
                        end
                    end
                end
                send_buffered: begin
                    out_valid <= 1'b1;
                    if (last_channel) begin
                        done <= 1'b1;
                        channel <= '0;
                        state <= idle;
                    end else begin
                        channel <= channel + 1'b1;
                        state <= wait_ready;
                    end
                end
                wait_ready: begin
                    // Back-pressure only holds a replay between words
                    if (out_ready) begin
                        state <= send_buffered;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Buffers start at zero, so a replay before any fetch sends zeros
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int ch = 0; ch < `MOVER_MAX_CHANNELS; ch++) begin
                data_buffers[ch] <= '0;
            end
        end else if (capture) begin
            data_buffers[channel] <= response_data;
        end
    end

    // Payload of requests and output words, qualified by the pulses above
    always_ff @(posedge clock) begin
        if (state == read_source) begin
            request_address <= source_address[channel];
        end
        if (capture) begin
            out_data <= response_data;
        end else if (replay) begin
            out_data <= data_buffers[channel];
        end
        // Tag and user come from the current registers, also on a replay
        if (capture || replay) begin
            out_dest <= dest_tag[channel];
            out_user <= user_value[channel];
        end
    end

endmodule

`default_nettype wire

// ==== logic/data_mover_top.sv ====
// Top level of the data mover, joining the register bank, the data point store and the sequencer
`timescale 1ns/10ps
`default_nettype none

`include "mover_settings.svh"

module data_mover_top (
    input wire logic clock,
    input wire logic reset,
    input wire logic reg_write,
    input wire logic reg_read,
    input wire mover_regs_pkg::reg_addr_t reg_address,
    input wire mover_regs_pkg::reg_word_t reg_write_data,
    output mover_regs_pkg::reg_word_t reg_read_data,
    input wire logic store_write,
    input wire mover_stream_pkg::src_addr_t store_address,
    input wire mover_stream_pkg::data_word_t store_write_data,
    input wire logic start,
    input wire logic repeat_outputs,
    input wire logic out_ready,
    output logic out_valid,
    output logic done,
    output mover_stream_pkg::data_word_t out_data,
    output mover_stream_pkg::dest_tag_t out_dest,
    output mover_stream_pkg::user_word_t out_user
);

    // Configuration levels from the register bank
    mover_regs_pkg::channel_count_t n_channels;
    mover_stream_pkg::src_addr_t source_address [`MOVER_MAX_CHANNELS];
    mover_stream_pkg::dest_tag_t dest_tag [`MOVER_MAX_CHANNELS];
    mover_stream_pkg::user_word_t user_value [`MOVER_MAX_CHANNELS];

    // Request and response between the sequencer and the store
    logic request_valid;
    mover_stream_pkg::src_addr_t request_address;
    logic response_valid;
    mover_stream_pkg::data_word_t response_data;

    register_bank register_bank_i (
        .clock(clock),
        .reset(reset),
        .reg_write(reg_write),
        .reg_read(reg_read),
        .reg_address(reg_address),
        .reg_write_data(reg_write_data),
        .reg_read_data(reg_read_data),
        .n_channels(n_channels),
        .source_address(source_address),
        .dest_tag(dest_tag),
        .user_value(user_value)
    );

    datapoint_store datapoint_store_i (
        .clock(clock),
        .reset(reset),
        .store_write(store_write),
        .store_address(store_address),
        .store_write_data(store_write_data),
        .request_valid(request_valid),
        .request_address(request_address),
        .response_valid(response_valid),
        .response_data(response_data)
    );

    data_mover data_mover_i (
        .clock(clock),
        .reset(reset),
        .start(start),
        .repeat_outputs(repeat_outputs),
        .out_ready(out_ready),
        .n_channels(n_channels),
        .source_address(source_address),
        .dest_tag(dest_tag),
        .user_value(user_value),
        .request_valid(request_valid),
        .request_address(request_address),
        .response_valid(response_valid),
        .response_data(response_data),
        .out_valid(out_valid),
        .done(done),
        .out_data(out_data),
        .out_dest(out_dest),
        .out_user(out_user)
    );

endmodule

`default_nettype wire

// ==== logic/datapoint_store.sv ====
// Dual port data point memory, loaded from outside and read back by the data mover
`timescale 1ns/10ps
`default_nettype none

`include "mover_settings.svh"

module datapoint_store (
    input wire logic clock,
    input wire logic reset,
    input wire logic store_write,
    input wire mover_stream_pkg::src_addr_t store_address,
    input wire mover_stream_pkg::data_word_t store_write_data,
    input wire logic request_valid,
    input wire mover_stream_pkg::src_addr_t request_address,
    output logic response_valid,
    output mover_stream_pkg::data_word_t response_data
);

    import mover_stream_pkg::*;

    data_word_t memory [`MOVER_STORE_DEPTH];

    // Only the low address bits select a word, the upper bits are ignored
    store_index_t write_index;
    store_index_t read_index;

    assign write_index = store_address[store_index_width-1:0];
    assign read_index = request_address[store_index_width-1:0];

    // Load port from outside
    always_ff @(posedge clock) begin
        if (store_write) begin
            memory[write_index] <= store_write_data;
        end
    end

    // Read port for the mover
    // A read and a load of the same word at one edge return the old contents
    always_ff @(posedge clock) begin
        if (request_valid) begin
            response_data <= memory[read_index];
        end
    end

    // The answer is flagged exactly one cycle after its request
    always_ff @(posedge clock) begin
        if (!reset) begin
            response_valid <= 1'b0;
        end else begin
            response_valid <= request_valid;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mover_regs_pkg.sv ====
// Register map of the data mover: word types, fixed indices and index helpers
`default_nettype none

`include "mover_settings.svh"

package mover_regs_pkg;

    typedef logic [31:0] reg_word_t;
    typedef logic [`MOVER_REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [$clog2(`MOVER_MAX_CHANNELS)-1:0] channel_idx_t;
    // One extra bit so that a full count of channels is representable
    typedef logic [$clog2(`MOVER_MAX_CHANNELS+1)-1:0] channel_count_t;

    // Index 0 is the channel count, then one address and one user register per channel
    localparam int n_channels_index = 0;
    localparam int addr_reg_base = 1;
    localparam int user_reg_base = addr_reg_base + `MOVER_MAX_CHANNELS;
    localparam int n_registers = user_reg_base + `MOVER_MAX_CHANNELS;

    // Field positions inside an address register
    localparam int src_field_lsb = 0;
    localparam int dest_field_lsb = 16;

    function automatic reg_addr_t addr_reg_index(input channel_idx_t channel);
        return reg_addr_t'(addr_reg_base + int'(channel));
    endfunction

    function automatic reg_addr_t user_reg_index(input channel_idx_t channel);
        return reg_addr_t'(user_reg_base + int'(channel));
    endfunction

    // Keeps a written channel count inside 1 .. MOVER_MAX_CHANNELS
    function automatic channel_count_t clamp_channel_count(input reg_word_t value);
        if (value == '0) begin
            return channel_count_t'(1);
        end
        if (value > reg_word_t'(`MOVER_MAX_CHANNELS)) begin
            return channel_count_t'(`MOVER_MAX_CHANNELS);
        end
        return channel_count_t'(value);
    endfunction

endpackage

`default_nettype wire

// ==== logic/mover_settings.svh ====
// Build-time sizes shared by the register bank, data point store and data mover
`ifndef MOVER_SETTINGS_SVH
`define MOVER_SETTINGS_SVH

// Width of one data point as it leaves the store and travels on the output stream
`define MOVER_DATA_WIDTH 32

// Number of channels the mover is built for
// The register map and the replay buffers both scale with it
`define MOVER_MAX_CHANNELS 4

// Width of a source address in the store and of a destination tag on the stream
// Both share one address register, so together they fill a 32 bit word
`define MOVER_ADDR_WIDTH 16

// Number of words held by the data point store
`define MOVER_STORE_DEPTH 256

// Width of the register bus address
// Sixteen slots cover the nine registers with room to spare
`define MOVER_REG_ADDR_WIDTH 4

`endif

// ==== logic/mover_stream_pkg.sv ====
// Payload types carried between the store, the mover and the output stream
`default_nettype none

`include "mover_settings.svh"

package mover_stream_pkg;

    // Address of a data point in the store, as software programs it
    typedef logic [`MOVER_ADDR_WIDTH-1:0] src_addr_t;

    // Destination tag sent along with each output word
    typedef logic [`MOVER_ADDR_WIDTH-1:0] dest_tag_t;

    // User sideband value, one full register word per channel
    typedef logic [31:0] user_word_t;

    // One data point
    typedef logic [`MOVER_DATA_WIDTH-1:0] data_word_t;

    // The store decodes only the low bits of a source address
    localparam int store_index_width = $clog2(`MOVER_STORE_DEPTH);
    typedef logic [store_index_width-1:0] store_index_t;

endpackage

`default_nettype wire

// ==== logic/register_bank.sv ====
// Register bus slave holding the channel count and the per channel address and user registers
`timescale 1ns/10ps
`default_nettype none

`include "mover_settings.svh"

module register_bank (
    input wire logic clock,
    input wire logic reset,
    input wire logic reg_write,
    input wire logic reg_read,
    input wire mover_regs_pkg::reg_addr_t reg_address,
    input wire mover_regs_pkg::reg_word_t reg_write_data,
    output mover_regs_pkg::reg_word_t reg_read_data,
    output mover_regs_pkg::channel_count_t n_channels,
    output mover_stream_pkg::src_addr_t source_address [`MOVER_MAX_CHANNELS],
    output mover_stream_pkg::dest_tag_t dest_tag [`MOVER_MAX_CHANNELS],
    output mover_stream_pkg::user_word_t user_value [`MOVER_MAX_CHANNELS]
);

    import mover_regs_pkg::*;
    import mover_stream_pkg::*;

    // Raw address registers, source in the low half and destination tag in the high half
    reg_word_t address_regs [`MOVER_MAX_CHANNELS];
    reg_word_t user_regs [`MOVER_MAX_CHANNELS];

    // Everything software can read, laid out by register index
    reg_word_t readback [n_registers];

    always_comb begin
        readback[n_channels_index] = reg_word_t'(n_channels);
        for (int ch = 0; ch < `MOVER_MAX_CHANNELS; ch++) begin
            readback[addr_reg_base + ch] = address_regs[ch];
            readback[user_reg_base + ch] = user_regs[ch];
        end
    end

    // Split the address registers into the fields the mover consumes
    always_comb begin
        for (int ch = 0; ch < `MOVER_MAX_CHANNELS; ch++) begin
            source_address[ch] = address_regs[ch][src_field_lsb +: $bits(src_addr_t)];
            dest_tag[ch] = address_regs[ch][dest_field_lsb +: $bits(dest_tag_t)];
            user_value[ch] = user_regs[ch];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            // One active channel is the smallest useful configuration
            n_channels <= channel_count_t'(1);
            for (int ch = 0; ch < `MOVER_MAX_CHANNELS; ch++) begin
                address_regs[ch] <= '0;
                user_regs[ch] <= '0;
            end
            reg_read_data <= '0;
        end else begin
            if (reg_write) begin
                if (reg_address == reg_addr_t'(n_channels_index)) begin
                    n_channels <= clamp_channel_count(reg_write_data);
                end
                for (int ch = 0; ch < `MOVER_MAX_CHANNELS; ch++) begin
                    if (reg_address == addr_reg_index(channel_idx_t'(ch))) begin
                        address_regs[ch] <= reg_write_data;
                    end
                    if (reg_address == user_reg_index(channel_idx_t'(ch))) begin
                        user_regs[ch] <= reg_write_data;
                    end
                end
            end
            // A read in the same cycle as a write returns the value before the write
            if (reg_read) begin
                if (int'(reg_address) < n_registers) begin
                    reg_read_data <= readback[reg_address];
                end else begin
                    // Unmapped slots read as zero
                    reg_read_data <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/data_mover_chk.sv ====
// Concurrent checks on the output pulses of the data mover top level
`timescale 1ns/10ps
`default_nettype none

module data_mover_chk (
    input wire logic clock,
    input wire logic reset,
    input wire logic out_valid,
    input wire logic done
);

    // Number of assertion failures seen so far
    int failures = 0;

    // The sequencer clears its output pulses while reset is low
    pulses_clear_after_reset: assert property (@(posedge clock) !reset |=> !out_valid && !done)
        else begin
            failures++;
            $error("out_valid or done was high in the cycle after reset");
        end

    // A sweep ends on a word, never on its own
    done_with_word: assert property (@(posedge clock) disable iff (!reset) done |-> out_valid)
        else begin
            failures++;
            $error("done was high without out_valid");
        end

    // Every word is a single cycle pulse, even when replayed with out_ready held high
    single_cycle_word: assert property (@(posedge clock) disable iff (!reset)
        out_valid |=> !out_valid)
        else begin
            failures++;
            $error("out_valid stayed high for two cycles in a row");
        end

endmodule

bind data_mover_top data_mover_chk data_mover_chk_i (
    .clock(clock),
    .reset(reset),
    .out_valid(out_valid),
    .done(done)
);

`default_nettype wire

// ==== verif/data_mover_tb.sv ====
// Directed testbench for the data mover covering register access, fetch sweeps and replays
`timescale 1ns/10ps
`default_nettype none

`include "mover_settings.svh"

module data_mover_tb;

    import mover_regs_pkg::*;
    import mover_stream_pkg::*;

    localparam int clock_period = 4;
    localparam int n_ch = `MOVER_MAX_CHANNELS;
    // Channel count, then one address and one user register per channel
    localparam int n_regs = 1 + 2 * n_ch;
    // Longest run of out_ready low that a replay is put through
    localparam int max_stall = 8;
    // A fetch takes 3 cycles per word, a replay at most max_stall plus 2 per word
    localparam int sweep_cycles = (max_stall + 2) * n_ch + 8;
    // Store load, register traffic and five sweeps, then doubled as margin
    localparam int run_cycles = 4 + `MOVER_STORE_DEPTH + 100 + 5 * sweep_cycles;
    localparam int watchdog_ns = 2 * run_cycles * clock_period;

    logic clock;
    logic reset;
    logic reg_write;
    logic reg_read;
    reg_addr_t reg_address;
    reg_word_t reg_write_data;
    reg_word_t reg_read_data;
    logic store_write;
    src_addr_t store_address;
    data_word_t store_write_data;
    logic start;
    logic repeat_outputs;
    logic out_ready;
    logic out_valid;
    logic done;
    data_word_t out_data;
    dest_tag_t out_dest;
    user_word_t out_user;

    // Reference copies of the store, the channel registers and the mover's replay buffers
    data_word_t store_model [`MOVER_STORE_DEPTH];
    src_addr_t src_model [n_ch];
    dest_tag_t dest_model [n_ch];
    user_word_t user_model [n_ch];
    data_word_t buffer_model [n_ch];
    int n_model;

    int seed = 32'hfec0fd24;
    int errors = 0;
    int tests_run = 0;

    data_mover_top data_mover_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("Test failed");
        $finish;
    end

    task automatic report_error(input string message);
        errors++;
        $display("[ERROR] %0t: %s", $time, message);
    endtask

    task automatic test_done(input string name, input int errors_before);
        tests_run++;
        $display("%s finished with %0d errors", name, errors - errors_before);
    endtask

    // Moves to 1 ns after the next rising edge, where inputs change and outputs are settled
    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic write_reg(input int index, input reg_word_t value);
        reg_write = 1'b1;
        reg_address = reg_addr_t'(index);
        reg_write_data = value;
        step();
        reg_write = 1'b0;
    endtask

    // Read data is registered at the edge that samples reg_read
    task automatic read_check(input int index, input reg_word_t expected);
        reg_read = 1'b1;
        reg_address = reg_addr_t'(index);
        step();
        reg_read = 1'b0;
        assert (reg_read_data == expected) else
            report_error($sformatf("register %0d reads %h, expected %h",
                index, reg_read_data, expected));
    endtask

    task automatic load_store(input int address, input data_word_t value);
        store_write = 1'b1;
        store_address = src_addr_t'(address);
        store_write_data = value;
        step();
        store_write = 1'b0;
        // Only the low address bits select a store word
        store_model[address % `MOVER_STORE_DEPTH] = value;
    endtask

    task automatic program_channel(input int ch);
        src_model[ch] = src_addr_t'($random(seed));
        dest_model[ch] = dest_tag_t'($random(seed));
        user_model[ch] = $random(seed);
        write_reg(1 + ch, {dest_model[ch], src_model[ch]});
        write_reg(1 + n_ch + ch, user_model[ch]);
    endtask

    // Counts below 1 read back as 1 and counts above the channel limit as the limit
    function automatic reg_word_t expected_count(input reg_word_t value);
        if (value == 0) begin
            return 1;
        end
        return (value > n_ch) ? n_ch : value;
    endfunction

    task automatic check_word(input data_word_t data, input int ch, input bit last);
        assert (out_valid) else
            report_error($sformatf("word of channel %0d is missing", ch));
        assert (out_data == data) else
            report_error($sformatf("channel %0d data is %h, expected %h", ch, out_data, data));
        assert (out_dest == dest_model[ch] && out_user == user_model[ch]) else
            report_error($sformatf("channel %0d tag/user are %h/%h, expected %h/%h",
                ch, out_dest, out_user, dest_model[ch], user_model[ch]));
        assert (done == last) else
            report_error($sformatf("done is %b with the word of channel %0d", done, ch));
    endtask

    task automatic check_quiet();
        assert (!out_valid && !done) else
            report_error("out_valid or done is high where no word is due");
    endtask

    // Word i of a fetch appears 3 * (i + 1) edges after the edge that samples start
    // A full fetch period after the last word stays quiet, so no extra word slips in
    task automatic fetch_sweep(input bit poke_start);
        data_word_t expected;
        start = 1'b1;
        step();
        start = 1'b0;
        for (int e = 1; e <= 3 * n_model + 6; e++) begin
            // A second start in the middle of the sweep must be ignored
            start = poke_start && (e == 4);
            step();
            if (e % 3 == 0 && e / 3 <= n_model) begin
                expected = store_model[src_model[e / 3 - 1] % `MOVER_STORE_DEPTH];
                buffer_model[e / 3 - 1] = expected;
                check_word(expected, e / 3 - 1, e / 3 == n_model);
            end else begin
                check_quiet();
            end
        end
    endtask

    // Word 0 follows the edge after repeat_outputs, each later word one edge after
    // an edge that samples out_ready high
    task automatic repeat_sweep(input bit with_start);
        int low_run;
        repeat_outputs = 1'b1;
        start = with_start;
        step();
        repeat_outputs = 1'b0;
        start = 1'b0;
        step();
        check_word(buffer_model[0], 0, n_model == 1);
        for (int i = 1; i < n_model; i++) begin
            low_run = 0;
            do begin
                out_ready = ($random(seed) & 1) || (low_run == max_stall);
                low_run++;
                step();
                check_quiet();
            end while (!out_ready);
            out_ready = 1'($random(seed));
            step();
            check_word(buffer_model[i], i, i == n_model - 1);
        end
        out_ready = 1'b0;
        repeat (3) begin
            step();
            check_quiet();
        end
    endtask

    task automatic test_register_readback();
        int errors_before = errors;
        reg_word_t values [n_regs];
        for (int r = 0; r < n_regs; r++) begin
            values[r] = $random(seed);
            write_reg(r, values[r]);
        end
        for (int r = 0; r < n_regs; r++) begin
            read_check(r, (r == 0) ? expected_count(values[0]) : values[r]);
        end
        write_reg(0, 0);
        read_check(0, 1);
        write_reg(0, 9);
        read_check(0, n_ch);
        // Slots past the register map
        read_check(n_regs, 0);
        read_check(2 ** `MOVER_REG_ADDR_WIDTH - 1, 0);
        test_done("register readback", errors_before);
    endtask

    task automatic test_single_fetch();
        int errors_before = errors;
        n_model = 1;
        write_reg(0, n_model);
        program_channel(0);
        fetch_sweep(1'b0);
        test_done("single channel fetch", errors_before);
    endtask

    task automatic test_multi_fetch();
        int errors_before = errors;
        n_model = n_ch;
        write_reg(0, n_model);
        for (int ch = 0; ch < n_ch; ch++) begin
            program_channel(ch);
        end
        out_ready = 1'b0;
        fetch_sweep(1'b0);
        test_done("multi channel fetch timing", errors_before);
    endtask

    task automatic test_repeat_backpressure();
        int errors_before = errors;
        // New store contents must not reach a replay
        for (int ch = 0; ch < n_ch; ch++) begin
            load_store(int'(src_model[ch]), $random(seed));
        end
        repeat_sweep(1'b0);
        test_done("repeat with back-pressure", errors_before);
    endtask

    task automatic test_reconfigure();
        int errors_before = errors;
        n_model = n_ch - 1;
        write_reg(0, n_model);
        for (int ch = 0; ch < n_model; ch++) begin
            program_channel(ch);
        end
        // Start and repeat together replay the old words under the new tags
        repeat_sweep(1'b1);
        fetch_sweep(1'b1);
        test_done("reconfiguration and priority", errors_before);
    endtask

    initial begin
        reset = 1'b0;
        reg_write = 1'b0;
        reg_read = 1'b0;
        reg_address = '0;
        reg_write_data = '0;
        store_write = 1'b0;
        store_address = '0;
        store_write_data = '0;
        start = 1'b0;
        repeat_outputs = 1'b0;
        out_ready = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b1;
        for (int a = 0; a < `MOVER_STORE_DEPTH; a++) begin
            load_store(a, $random(seed));
        end
        test_register_readback();
        test_single_fetch();
        test_multi_fetch();
        test_repeat_backpressure();
        test_reconfigure();
        $display("%0d tests run, %0d check errors, %0d assertion failures", tests_run, errors,
            data_mover_top_i.data_mover_chk_i.failures);
        if (errors == 0 && data_mover_top_i.data_mover_chk_i.failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
